// ==== project.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/predict_if.sv
hw/table_init_counter.sv
hw/fetch_control.sv
hw/branch_predictor.sv
hw/slot_predecode.sv
hw/fetch_queue.sv
hw/fetch_unit.sv
verification/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_fetch_unit -o tb_fetch_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_fetch_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== verification/tb_fetch_unit.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module tb_fetch_unit
    import fetch_pkg::*;
();

    localparam int NUM_PACKETS  = 300;
    localparam int RESET_CYCLES = 8;
    localparam int PROG_WORDS   = 128;
    // About a dozen cycles per packet covers latency, stalls and flushed fetches
    localparam int CYCLE_LIMIT  = RESET_CYCLES + `TABLE_DEPTH + NUM_PACKETS * 13;

    logic             clk;
    logic             rst;
    logic [`PC_W-1:0] req_addr;
    logic             req_valid;
    logic             req_ready;
    logic [63:0]      resp_data;
    logic             resp_valid;
    logic             dec_valid0;
    logic [`PC_W-1:0] dec_pc0;
    logic [31:0]      dec_instr0;
    logic             dec_bp0;
    logic [`PC_W-1:0] dec_bt0;
    logic             dec_valid1;
    logic [`PC_W-1:0] dec_pc1;
    logic [31:0]      dec_instr1;
    logic             dec_bp1;
    logic [`PC_W-1:0] dec_bt1;
    logic             dec_ready;
    logic             br_valid;
    logic             br_taken;
    logic [`PC_W-1:0] br_pc;
    logic [`PC_W-1:0] br_target;
    logic             pc_override;
    logic [`PC_W-1:0] new_pc;

    integer            seed;
    logic [31:0]       program_mem [PROG_WORDS];
    // Mirror of the predictor tables
    logic              m_valid  [`TABLE_DEPTH];
    logic [`TAG_W-1:0] m_tag    [`TABLE_DEPTH];
    logic [31:0]       m_target [`TABLE_DEPTH];
    logic [1:0]        m_count  [`TABLE_DEPTH];
    // Packets the decoder should see with the oldest first
    fetch_packet_t     exp_q [$];
    // Fetch in flight at the memory
    fetch_packet_t     pend_pkt;
    logic [31:0]       pend_next;
    logic [31:0]       pend_addr;
    logic              pend_stale;
    logic              mem_pending;
    int                mem_delay;
    logic [31:0]       exp_pc;
    logic              started;
    int                settle;
    int                delivered;
    int                cycle_count = 0;

    fetch_unit uut (.*);

    function automatic int unsigned pick(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Upper address bits fold into the operand fields and leave the opcode intact
    function automatic logic [31:0] word_at(logic [31:0] addr);
        return program_mem[addr[8:2]] ^ {addr[31:7], 7'b0};
    endfunction

    function automatic logic [31:0] window_addr();
        return `RESET_VECTOR + 32'(pick(PROG_WORDS) * 4);
    endfunction

    function automatic logic is_control(logic [31:0] instr);
        return instr[6:0] == BRANCH || instr[6:0] == JAL || instr[6:0] == JALR;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_quiet(input string phase);
        assert (req_valid === 1'b0 && dec_valid0 === 1'b0 && dec_valid1 === 1'b0)
        else abort_run($sformatf("request or decoder valid during %s", phase));
    endtask

    // Expected packet and next fetch address for a fetch at pc
    task automatic predict_packet(input logic [31:0] pc, output fetch_packet_t pkt,
                                  output logic [31:0] nxt);
        logic [31:0]             base;
        logic [`TABLE_ABITS-1:0] idx [2];
        logic                    cti [2];
        logic                    take [2];
        logic [31:0]             tgt [2];
        logic                    first_ok;
        logic                    pair;
        base     = {pc[31:3], 3'b000};
        first_ok = !pc[2];
        for (int i = 0; i < 2; i++) begin
            // Even word for slot0, odd word for slot1
            idx[i]  = {pc[`TABLE_ABITS+1:3], 1'(i)};
            cti[i]  = is_control(word_at(base + 32'(4 * i)));
            tgt[i]  = m_target[idx[i]];
            take[i] = cti[i] && m_valid[idx[i]] && m_count[idx[i]][1]
                      && m_tag[idx[i]] == pc[31:`TABLE_ABITS+2];
        end
        take[0] = take[0] && first_ok;
        pair    = first_ok && cti[0] && cti[1];
        if (take[0]) begin
            nxt = tgt[0];
        end else if (pair) begin
            nxt = base + 32'd4;
        end else if (take[1]) begin
            nxt = tgt[1];
        end else begin
            nxt = base + 32'd8;
        end
        pkt.slot0.pc    = base;
        pkt.slot0.instr = word_at(base);
        pkt.slot0.bp    = take[0];
        pkt.slot0.bt    = take[0] ? tgt[0] : base + 32'd4;
        pkt.slot0.valid = first_ok;
        pkt.slot1.pc    = base + 32'd4;
        pkt.slot1.instr = word_at(base + 32'd4);
        pkt.slot1.valid = !take[0] && !pair;
        pkt.slot1.bp    = take[1] && pkt.slot1.valid;
        pkt.slot1.bt    = nxt;
    endtask

    task automatic train_model(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        logic [`TABLE_ABITS-1:0] idx;
        idx = pc[`TABLE_ABITS+1:2];
        if (taken && m_count[idx] != 2'b11) begin
            m_count[idx] = m_count[idx] + 2'b01;
        end else if (!taken && m_count[idx] != 2'b00) begin
            m_count[idx] = m_count[idx] - 2'b01;
        end
        // Only taken branches allocate in the BTB
        if (taken) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = pc[31:`TABLE_ABITS+2];
            m_target[idx] = {target[31:2], 2'b00};
        end
    endtask

    task automatic compare_head(input fetch_packet_t exp);
        check_value("dec_valid0", 32'(dec_valid0), 32'(exp.slot0.valid));
        check_value("dec_valid1", 32'(dec_valid1), 32'(exp.slot1.valid));
        if (exp.slot0.valid) begin
            check_value("dec_pc0", dec_pc0, exp.slot0.pc);
            check_value("dec_instr0", dec_instr0, exp.slot0.instr);
            check_value("dec_bp0", 32'(dec_bp0), 32'(exp.slot0.bp));
            check_value("dec_bt0", dec_bt0, exp.slot0.bt);
        end
        if (exp.slot1.valid) begin
            check_value("dec_pc1", dec_pc1, exp.slot1.pc);
            check_value("dec_instr1", dec_instr1, exp.slot1.instr);
            check_value("dec_bp1", 32'(dec_bp1), 32'(exp.slot1.bp));
            check_value("dec_bt1", dec_bt1, exp.slot1.bt);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles, %0d of %0d packets delivered",
                                cycle_count, delivered, NUM_PACKETS));
        end
    end

    initial begin
        logic accept;
        logic resp_fire;
        logic take;
        seed        = 51184;
        rst         = 1'b1;
        req_ready   = 1'b0;
        resp_valid  = 1'b0;
        resp_data   = '0;
        dec_ready   = 1'b0;
        br_valid    = 1'b0;
        br_taken    = 1'b0;
        br_pc       = '0;
        br_target   = '0;
        pc_override = 1'b0;
        new_pc      = '0;
        // Random program with branches, jal and jalr mixed in
        for (int i = 0; i < PROG_WORDS; i++) begin
            program_mem[i] = $random(seed);
            case (pick(8))
                0: program_mem[i][6:0] = BRANCH;
                1: program_mem[i][6:0] = JAL;
                2: program_mem[i][6:0] = JALR;
                default: program_mem[i][6:0] = 7'b0010011;
            endcase
        end
        for (int i = 0; i < `TABLE_DEPTH; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_count[i]  = 2'b01;
        end
        exp_pc      = `RESET_VECTOR;
        mem_pending = 1'b0;
        mem_delay   = 0;
        pend_stale  = 1'b0;
        started     = 1'b0;
        settle      = 0;
        delivered   = 0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_quiet("reset");
        end
        rst = 1'b0;

        while (delivered < NUM_PACKETS) begin
            @(negedge clk);
            // Outputs are settled since the last rising edge
            if (settle < `TABLE_DEPTH) begin
                check_quiet("table init");
                settle++;
            end
            if (req_valid) begin
                // One fetch in flight at most and never into a full queue
                assert (!mem_pending && exp_q.size() < `QUEUE_DEPTH)
                else abort_run("request raised while a response is owed or the queue is full");
                check_value("req_addr", req_addr, exp_pc);
            end
            if (exp_q.size() == 0) begin
                assert (!dec_valid0 && !dec_valid1)
                else abort_run("decoder valid while no packet is due");
            end else begin
                compare_head(exp_q[0]);
            end

            // Memory answers after a latency of 1 to 3 cycles
            resp_fire  = 1'b0;
            resp_valid = 1'b0;
            resp_data  = {$random(seed), $random(seed)};
            if (mem_pending) begin
                mem_delay--;
                if (mem_delay == 0) begin
                    resp_fire   = 1'b1;
                    mem_pending = 1'b0;
                    resp_valid  = 1'b1;
                    resp_data   = {word_at(pend_addr + 32'd4), word_at(pend_addr)};
                end
            end
            req_ready = pick(4) != 0;
            accept    = req_valid && req_ready;
            dec_ready = pick(4) != 0;
            take      = exp_q.size() != 0 && dec_ready;
            // Execute stage traffic once the tables are live
            pc_override = started && pick(24) == 0;
            new_pc      = window_addr();
            br_valid    = started && pick(3) == 0;
            br_taken    = pick(4) != 0;
            br_pc       = window_addr();
            br_target   = window_addr();

            // Model the coming edge where the lookup reads the tables before training
            if (accept) begin
                predict_packet(exp_pc, pend_pkt, pend_next);
                pend_addr   = {exp_pc[31:3], 3'b000};
                pend_stale  = 1'b0;
                mem_pending = 1'b1;
                mem_delay   = 1 + int'(pick(3));
                started     = 1'b1;
            end
            if (take) begin
                void'(exp_q.pop_front());
                delivered++;
            end
            if (resp_fire && !pend_stale && !pc_override) begin
                exp_q.push_back(pend_pkt);
                exp_pc = pend_next;
            end
            if (pc_override) begin
                // Flush the queue and mark whatever the memory still owes as stale
                exp_q.delete();
                exp_pc = new_pc;
                if (mem_pending) begin
                    pend_stale = 1'b1;
                end
            end
            if (br_valid) begin
                train_model(br_pc, br_taken, br_target);
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    // Instruction memory
    output logic [`PC_W-1:0] req_addr,
    output logic             req_valid,
    input  logic             req_ready,
    input  logic [63:0]      resp_data,
    input  logic             resp_valid,
    // Decoder, slot0 lower address
    output logic             dec_valid0,
    output logic [`PC_W-1:0] dec_pc0,
    output logic [31:0]      dec_instr0,
    output logic             dec_bp0,
    output logic [`PC_W-1:0] dec_bt0,
    output logic             dec_valid1,
    output logic [`PC_W-1:0] dec_pc1,
    output logic [31:0]      dec_instr1,
    output logic             dec_bp1,
    output logic [`PC_W-1:0] dec_bt1,
    input  logic             dec_ready,
    // Resolved branches and redirect from execute
    input  logic             br_valid,
    input  logic             br_taken,
    input  logic [`PC_W-1:0] br_pc,
    input  logic [`PC_W-1:0] br_target,
    input  logic             pc_override,
    input  logic [`PC_W-1:0] new_pc
);

    logic                    init_active;
    logic [`TABLE_ABITS-1:0] init_index;
    logic                    queue_full;
    logic                    queue_valid;
    logic                    queue_flush;
    logic [`PC_W-1:0]        next_pc;
    logic [`PC_W-1:0]        fetch_pc;
    logic                    drop_resp;
    logic                    resp_accept;
    fetch_packet_t           wr_packet;
    fetch_packet_t           rd_packet;

    predict_if pif ();

    table_init_counter u_init (
        .clk         (clk),
        .rst         (rst),
        .init_active (init_active),
        .init_index  (init_index)
    );

    fetch_control u_control (
        .clk         (clk),
        .rst         (rst),
        .init_active (init_active),
        .queue_full  (queue_full),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .pc_override (pc_override),
        .new_pc      (new_pc),
        .next_pc     (next_pc),
        .drop_resp   (drop_resp),
        .resp_accept (resp_accept),
        .fetch_pc    (fetch_pc),
        .pif         (pif.ctrl)
    );

    branch_predictor u_predictor (
        .clk         (clk),
        .rst         (rst),
        .init_active (init_active),
        .init_index  (init_index),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_pc       (br_pc),
        .br_target   (br_target),
        .pif         (pif.tables)
    );

    slot_predecode u_predecode (
        .resp_data (resp_data),
        .fetch_pc  (fetch_pc),
        .pif       (pif.user),
        .packet    (wr_packet),
        .next_pc   (next_pc)
    );

    // Redirects and stale responses both clear the queue
    assign queue_flush = pc_override || drop_resp;

    fetch_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .flush     (queue_flush),
        .wr_en     (resp_accept),
        .wr_packet (wr_packet),
        .full      (queue_full),
        .rd_valid  (queue_valid),
        .rd_packet (rd_packet),
        .rd_ready  (dec_ready)
    );

    // Slot valids only count while the queue holds a packet
    assign dec_valid0 = queue_valid && rd_packet.slot0.valid;
    assign dec_pc0    = rd_packet.slot0.pc;
    assign dec_instr0 = rd_packet.slot0.instr;
    assign dec_bp0    = rd_packet.slot0.bp;
    assign dec_bt0    = rd_packet.slot0.bt;
    assign dec_valid1 = queue_valid && rd_packet.slot1.valid;
    assign dec_pc1    = rd_packet.slot1.pc;
    assign dec_instr1 = rd_packet.slot1.instr;
    assign dec_bp1    = rd_packet.slot1.bp;
    assign dec_bt1    = rd_packet.slot1.bt;

endmodule

// ==== hw/fetch_queue.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_queue
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          wr_en,
    input  fetch_packet_t wr_packet,
    output logic          full,
    output logic          rd_valid,
    output fetch_packet_t rd_packet,
    input  logic          rd_ready
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`QUEUE_DEPTH - 1);

    fetch_packet_t    mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign full      = count == (PTR_W+1)'(`QUEUE_DEPTH);
    assign rd_valid  = count != '0;
    // Head shows without waiting for a read
    assign rd_packet = mem[rd_ptr];
    assign do_wr     = wr_en && !full;
    assign do_rd     = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_packet;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_wr) - (PTR_W+1)'(do_rd);
        end
    end

    // Fetch controller only issues when there is room
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full)
        else $error("queue written while full");

endmodule

// ==== hw/slot_predecode.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module slot_predecode
    import fetch_pkg::*;
(
    input  logic [63:0]      resp_data,
    input  logic [`PC_W-1:0] fetch_pc,
    predict_if.user          pif,
    output fetch_packet_t    packet,
    output logic [`PC_W-1:0] next_pc
);

    // Control transfer opcodes, everything else folds to OTHER
    function automatic opcode_e classify(logic [6:0] op);
        case (op)
            BRANCH:  return BRANCH;
            JAL:     return JAL;
            JALR:    return JALR;
            default: return OTHER;
        endcase
    endfunction

    logic [`PC_W-1:0] aligned;
    logic [`PC_W-1:0] aligned_plus4;
    logic [`PC_W-1:0] aligned_plus8;
    logic [31:0]      instr0;
    logic [31:0]      instr1;
    logic             cti0;
    logic             cti1;
    logic             slot0_ok;
    logic             slot1_ok;
    logic             bp0;
    logic             bp1;
    logic             both_cti;

    assign aligned       = {fetch_pc[`PC_W-1:3], 3'b000};
    assign aligned_plus4 = aligned + `PC_W'(4);
    assign aligned_plus8 = aligned + `PC_W'(8);

    // Low word is the lower address
    assign instr0 = resp_data[31:0];
    assign instr1 = resp_data[63:32];
    assign cti0   = classify(instr0[6:0]) != OTHER;
    assign cti1   = classify(instr1[6:0]) != OTHER;

    // Entry at PC+4 skips the low word
    assign slot0_ok = !fetch_pc[2];

    // Taken needs a branch opcode, a BTB hit and a set counter MSB
    assign bp0 = slot0_ok && cti0 && pif.hit[0] && pif.taken[0];
    assign bp1 = cti1 && pif.hit[1] && pif.taken[1];

    // Only one branch per packet, the second is refetched alone
    assign both_cti = slot0_ok && cti0 && cti1;
    assign slot1_ok = !bp0 && !both_cti;

    always_comb begin
        if (bp0) begin
            next_pc = pif.target[0];
        end else if (both_cti) begin
            next_pc = aligned_plus4;
        end else if (bp1) begin
            next_pc = pif.target[1];
        end else begin
            next_pc = aligned_plus8;
        end
    end

    always_comb begin
        packet.slot0.pc    = aligned;
        packet.slot0.instr = instr0;
        packet.slot0.bp    = bp0;
        packet.slot0.bt    = bp0 ? pif.target[0] : aligned_plus4;
        packet.slot0.valid = slot0_ok;
        packet.slot1.pc    = aligned_plus4;
        packet.slot1.instr = instr1;
        packet.slot1.bp    = bp1 && slot1_ok;
        // When slot1 survives, the packet's next PC follows it
        packet.slot1.bt    = next_pc;
        packet.slot1.valid = slot1_ok;
    end

endmodule

// ==== hw/branch_predictor.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module branch_predictor
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    init_active,
    input  logic [`TABLE_ABITS-1:0] init_index,
    input  logic                    br_valid,
    input  logic                    br_taken,
    input  logic [`PC_W-1:0]        br_pc,
    input  logic [`PC_W-1:0]        br_target,
    predict_if.tables               pif
);

    // BTB fields kept in parallel arrays, target stored as a word address
    logic                    btb_valid  [`TABLE_DEPTH];
    logic [`TAG_W-1:0]       btb_tag    [`TABLE_DEPTH];
    logic [`PC_W-3:0]        btb_target [`TABLE_DEPTH];
    // Bimodal counters
    counter_t                bht        [`TABLE_DEPTH];

    logic [`TABLE_ABITS-1:0] rd_index [2];
    logic [`TAG_W-1:0]       rd_tag;
    logic [`TABLE_ABITS-1:0] wr_index;
    counter_t                wr_count;

    // Even word for slot0, odd word for slot1
    assign rd_index[0] = {pif.lookup_pc[`TABLE_ABITS+1:3], 1'b0};
    assign rd_index[1] = {pif.lookup_pc[`TABLE_ABITS+1:3], 1'b1};
    assign rd_tag      = pif.lookup_pc[`PC_W-1:`TABLE_ABITS+2];
    assign wr_index    = br_pc[`TABLE_ABITS+1:2];

    // Saturating update of the resolved branch's counter
    always_comb begin
        wr_count = bht[wr_index];
        if (br_taken && wr_count != 2'b11) begin
            wr_count = wr_count + 2'b01;
        end else if (!br_taken && wr_count != 2'b00) begin
            wr_count = wr_count - 2'b01;
        end
    end

    // Table writes, the init sweep has priority
    always_ff @(posedge clk) begin
        if (init_active) begin
            btb_valid[init_index] <= 1'b0;
            // Weakly not-taken
            bht[init_index]       <= 2'b01;
        end else if (br_valid) begin
            bht[wr_index] <= wr_count;
            // Only taken branches allocate a target
            if (br_taken) begin
                btb_valid[wr_index]  <= 1'b1;
                btb_tag[wr_index]    <= br_pc[`PC_W-1:`TABLE_ABITS+2];
                btb_target[wr_index] <= br_target[`PC_W-1:2];
            end
        end
    end

    // Lookup results, held until the next request
    always_ff @(posedge clk) begin
        if (rst) begin
            pif.hit   <= '0;
            pif.taken <= '0;
        end else if (pif.lookup_en) begin
            for (int i = 0; i < 2; i++) begin
                pif.hit[i]   <= btb_valid[rd_index[i]] && (btb_tag[rd_index[i]] == rd_tag);
                pif.taken[i] <= bht[rd_index[i]][1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pif.lookup_en) begin
            for (int i = 0; i < 2; i++) begin
                pif.target[i] <= {btb_target[rd_index[i]], 2'b00};
            end
        end
    end

    // Execute stage must not resolve branches before the sweep is done
    assert property (@(posedge clk) disable iff (rst)
        br_valid |-> !init_active)
        else $error("training write during table init");

endmodule

// ==== hw/fetch_control.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_control
    import fetch_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             init_active,
    input  logic             queue_full,
    input  logic             req_ready,
    input  logic             resp_valid,
    output logic             req_valid,
    output logic [`PC_W-1:0] req_addr,
    input  logic             pc_override,
    input  logic [`PC_W-1:0] new_pc,
    input  logic [`PC_W-1:0] next_pc,
    output logic             drop_resp,
    output logic             resp_accept,
    output logic [`PC_W-1:0] fetch_pc,
    predict_if.ctrl          pif
);

    fetch_state_e     state;
    // Address of the current fetch held until its response lands
    logic [`PC_W-1:0] pc;
    // Response in flight belongs to a fetch killed by a redirect
    logic             drop_pending;
    logic             req_fire;

    // No new request while the queue has no room
    assign req_valid = (state == REQUEST) && !queue_full;
    assign req_fire  = req_valid && req_ready;
    assign req_addr  = pc;
    assign fetch_pc  = pc;

    // Stale data is thrown away even when the redirect comes with it
    assign drop_resp   = resp_valid && (drop_pending || pc_override);
    assign resp_accept = resp_valid && (state == WAIT_RESP) && !drop_resp;

    // Predictor reads its tables on the same edge the memory takes the request
    assign pif.lookup_en = req_fire;
    assign pif.lookup_pc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= INIT;
            drop_pending <= 1'b0;
            pc           <= `RESET_VECTOR;
        end else begin
            case (state)
                INIT: begin
                    // Hold off until both tables are cleared
                    if (!init_active) begin
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (req_fire) begin
                        state <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    // Slot is free again whether the response was dropped or not
                    if (resp_valid) begin
                        state <= REQUEST;
                    end
                end
                default: state <= INIT;
            endcase

            // Remember the redirect if a response is still owed to the old path
            if (pc_override) begin
                drop_pending <= req_fire || (state == WAIT_RESP && !resp_valid);
            end else if (resp_valid) begin
                drop_pending <= 1'b0;
            end

            // Redirect wins over the predicted next PC
            if (pc_override) begin
                pc <= new_pc;
            end else if (resp_accept) begin
                pc <= next_pc;
            end
        end
    end

    // A raised request stays up with a steady address until the memory takes it
    assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready && !pc_override |=> req_valid && $stable(req_addr))
        else $error("request dropped or changed before acceptance");

    // Memory only answers a request that was accepted
    assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> state == WAIT_RESP)
        else $error("response with no request outstanding");

endmodule

// ==== hw/table_init_counter.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module table_init_counter (
    input  logic                    clk,
    input  logic                    rst,
    output logic                    init_active,
    output logic [`TABLE_ABITS-1:0] init_index
);

    localparam logic [`TABLE_ABITS-1:0] LAST_INDEX = `TABLE_ABITS'(`TABLE_DEPTH - 1);

    // Walk every table entry once, then stop
    always_ff @(posedge clk) begin
        if (rst) begin
            init_active <= 1'b1;
            init_index  <= '0;
        end else if (init_active) begin
            if (init_index == LAST_INDEX) begin
                init_active <= 1'b0;
            end
            init_index <= init_index + 1'b1;
        end
    end

    // Sweep ends exactly when the index rolls over
    assert property (@(posedge clk) disable iff (rst)
        init_active |=> (!init_active || init_index != '0))
        else $error("init sweep wrapped while still active");

endmodule

// ==== hw/predict_if.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

interface predict_if;

    // Lookup request, valid on request acceptance
    logic                   lookup_en;
    logic [`PC_W-1:0]       lookup_pc;

    // Per-slot results, index 0 is the even word
    logic [1:0]             hit;
    logic [1:0]             taken;
    logic [1:0][`PC_W-1:0]  target;

    // Fetch controller side
    modport ctrl (output lookup_en, lookup_pc);

    // Predictor table side
    modport tables (input lookup_en, lookup_pc, output hit, taken, target);

    // Pre-decoder reads the registered results
    modport user (input hit, taken, target);

endinterface

// ==== hw/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    // Fetch controller states
    typedef enum logic [1:0] {
        INIT,
        REQUEST,
        WAIT_RESP
    } fetch_state_e;

    // RV32 major opcodes of interest to the pre-decoder
    typedef enum logic [6:0] {
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        OTHER  = 7'b0000000
    } opcode_e;

    // Saturating 2-bit counter, MSB set means predict taken
    typedef logic [1:0] counter_t;

    // One decoder slot
    typedef struct packed {
        logic [`PC_W-1:0] pc;
        logic [31:0]      instr;
        logic             bp;
        logic [`PC_W-1:0] bt;
        logic             valid;
    } dec_slot_t;

    // slot0 sits at the lower address
    typedef struct packed {
        dec_slot_t slot1;
        dec_slot_t slot0;
    } fetch_packet_t;

endpackage

// ==== hw/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First fetch address after reset
`define RESET_VECTOR 32'h8000_0000

`define PC_W 32

// BTB and counter table geometry, both tables share one index
`define TABLE_ABITS 5
`define TABLE_DEPTH 32

// Tag covers the PC bits above the word index
`define TAG_W (`PC_W - `TABLE_ABITS - 2)

// Decoder packet queue
`define QUEUE_DEPTH 2

`endif
